/* bench/ladder_step_checker.sv */
`timescale 1ns/10ps

module ladder_step_checker #(
	parameter int W = ladder_pkg::field_w_default,
	parameter int P = ladder_pkg::field_p_default
) (
	input logic         clk,
	input logic         rst_n,
	input logic         en,
	input logic         out_valid,
	input logic [W-1:0] x_n,
	input logic [W-1:0] z_n,
	input logic [W-1:0] x_n1,
	input logic [W-1:0] z_n1
);

	localparam logic [W-1:0] p_w = W'(P);
	localparam logic [9:0] step_limit = 10'd400;

	// step in flight from accepted en to its out_valid
	logic       pending;
	logic [9:0] wait_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending  <= 1'b0;
			wait_cnt <= '0;
		end else begin
			// en in the out_valid cycle already finds the sequencer idle
			if (out_valid)
				pending <= en;
			else if (en)
				pending <= 1'b1;
			if (out_valid || !pending)
				wait_cnt <= '0;
			else
				wait_cnt <= wait_cnt + 10'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// output strobe and result range

	assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
		else $error("out_valid high on two consecutive cycles");

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (x_n < p_w) && (z_n < p_w) && (x_n1 < p_w) && (z_n1 < p_w))
		else $error("result at out_valid not reduced below the modulus");

	assert property (@(posedge clk) disable iff (!rst_n) wait_cnt < step_limit)
		else $error("no out_valid within 400 cycles of an accepted en");

endmodule

bind ladder_step ladder_step_checker #(.W(W), .P(P)) u_chk (
	.clk(clk), .rst_n(rst_n), .en(en), .out_valid(out_valid),
	.x_n(x_n), .z_n(z_n), .x_n1(x_n1), .z_n1(z_n1)
);

/* bench/ladder_step_tb.sv */
`timescale 1ns/10ps

module ladder_step_tb;

	localparam int W = 16;
	localparam int P = 65521;
	// cycles allowed for one step to finish
	localparam int wait_limit = 2000;

	logic         clk;
	logic         rst_n;
	logic         en;
	logic         b;
	logic [W-1:0] x_m;
	logic [W-1:0] z_m;
	logic [W-1:0] x_m1;
	logic [W-1:0] z_m1;
	logic [W-1:0] work;
	logic         out_valid;
	logic [W-1:0] x_n;
	logic [W-1:0] z_n;
	logic [W-1:0] x_n1;
	logic [W-1:0] z_n1;

	int check_pass;
	int check_fail;
	// failure count when the current test began
	int fail_at_start;

	ladder_step #(.W(W), .P(P)) u_dut (
		.clk(clk), .rst_n(rst_n), .en(en), .b(b),
		.x_m(x_m), .z_m(z_m), .x_m1(x_m1), .z_m1(z_m1), .work(work),
		.out_valid(out_valid), .x_n(x_n), .z_n(z_n), .x_n1(x_n1), .z_n1(z_n1)
	);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference field arithmetic, operands below P

	function automatic logic [W-1:0] mod_add(input logic [W-1:0] x, input logic [W-1:0] y);
		return W'((longint'(x) + longint'(y)) % P);
	endfunction

	function automatic logic [W-1:0] mod_sub(input logic [W-1:0] x, input logic [W-1:0] y);
		return W'((longint'(x) - longint'(y) + longint'(P)) % P);
	endfunction

	function automatic logic [W-1:0] mod_mul(input logic [W-1:0] x, input logic [W-1:0] y);
		return W'((longint'(x) * longint'(y)) % P);
	endfunction

	function automatic logic [W-1:0] rand_elem();
		return W'($urandom % P);
	endfunction

	// 0, 1 or P-1
	function automatic logic [W-1:0] edge_value(input int sel);
		if (sel == 0)
			return '0;
		else if (sel == 1)
			return W'(1);
		return W'(P - 1);
	endfunction

	// one ladder step in mainloop order
	task automatic model_step(input logic kb, input logic [W-1:0] xm, zm, xm1, zm1, w,
		output logic [W-1:0] xn, zn, xn1, zn1);
		logic [W-1:0] x2, z2, x3, z3;
		logic [W-1:0] a0_lo, a0_hi, a1_lo, a1_hi;
		logic [W-1:0] b0_lo, b0_hi, b1_lo, b1_hi, c1_lo, c1_hi;
		logic [W-1:0] r, s, t, u;
		logic [W-1:0] nb_x, nb_z, n1b_x, n1b_z;
		// swap in by key bit
		x2 = kb ? xm1 : xm;
		z2 = kb ? zm1 : zm;
		x3 = kb ? xm : xm1;
		z3 = kb ? zm : zm1;
		a0_lo = mod_add(x2, z2);
		a0_hi = mod_sub(x2, z2);
		a1_lo = mod_add(x3, z3);
		a1_hi = mod_sub(x3, z3);
		b0_lo = mod_mul(a0_lo, a0_lo);
		b0_hi = mod_mul(a0_hi, a0_hi);
		b1_lo = mod_mul(a1_lo, a0_hi);
		b1_hi = mod_mul(a1_hi, a0_lo);
		c1_lo = mod_add(b1_lo, b1_hi);
		c1_hi = mod_sub(b1_lo, b1_hi);
		r = mod_mul(c1_hi, c1_hi);
		s = mod_sub(b0_lo, b0_hi);
		// full curve constant, not pre-reduced
		t = W'((longint'(s) * 121665) % P);
		u = mod_add(t, b0_lo);
		nb_x = mod_mul(b0_lo, b0_hi);
		nb_z = mod_mul(s, u);
		n1b_x = mod_mul(c1_lo, c1_lo);
		n1b_z = mod_mul(r, w);
		// swap back
		xn = kb ? n1b_x : nb_x;
		zn = kb ? n1b_z : nb_z;
		xn1 = kb ? nb_x : n1b_x;
		zn1 = kb ? nb_z : n1b_z;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare and report

	task automatic check_elem(input string name, input logic [W-1:0] expected,
		input logic [W-1:0] actual);
		if (expected === actual) begin
			check_pass++;
		end else begin
			check_fail++;
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (expected === actual) begin
			check_pass++;
		end else begin
			check_fail++;
			$display("Error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic compare_outputs(input string name, input logic [W-1:0] ex, ez, ex1, ez1);
		check_elem({name, " x_n"}, ex, x_n);
		check_elem({name, " z_n"}, ez, z_n);
		check_elem({name, " x_n1"}, ex1, x_n1);
		check_elem({name, " z_n1"}, ez1, z_n1);
	endtask

	task automatic start_test();
		fail_at_start = check_fail;
	endtask

	task automatic finish_test(input string name);
		if (check_fail == fail_at_start)
			$display("%s: ok", name);
		else
			$display("%s: %0d failures", name, check_fail - fail_at_start);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	// en high for exactly one cycle
	task automatic pulse_en(input logic kb, input logic [W-1:0] xm, zm, xm1, zm1, w);
		@(posedge clk);
		en   <= 1'b1;
		b    <= kb;
		x_m  <= xm;
		z_m  <= zm;
		x_m1 <= xm1;
		z_m1 <= zm1;
		work <= w;
		@(posedge clk);
		en <= 1'b0;
	endtask

	// sampled at negedge, outputs settled
	task automatic wait_valid(input string name);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (!out_valid && cnt < wait_limit) begin
			@(negedge clk);
			cnt++;
		end
		if (!out_valid) begin
			check_fail++;
			$display("%s: out_valid never came within %0d cycles", name, wait_limit);
		end
	endtask

	task automatic check_step(input string name, input logic kb,
		input logic [W-1:0] xm, zm, xm1, zm1, w);
		logic [W-1:0] ex, ez, ex1, ez1;
		model_step(kb, xm, zm, xm1, zm1, w, ex, ez, ex1, ez1);
		pulse_en(kb, xm, zm, xm1, zm1, w);
		wait_valid(name);
		compare_outputs(name, ex, ez, ex1, ez1);
	endtask

	initial begin
		logic [W-1:0] mx, mz, mx1, mz1;
		logic [W-1:0] dx, dz, dx1, dz1;
		logic [W-1:0] w;
		logic [15:0]  k;
		logic         kb;
		void'($urandom(73677));
		check_pass = 0;
		check_fail = 0;
		fail_at_start = 0;
		rst_n = 1'b0;
		en    = 1'b0;
		b     = 1'b0;
		x_m   = '0;
		z_m   = '0;
		x_m1  = '0;
		z_m1  = '0;
		work  = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// quiet after reset
		start_test();
		repeat (10) begin
			@(negedge clk);
			check_bit("reset_idle out_valid", 1'b0, out_valid);
		end
		finish_test("reset_idle");

		start_test();
		for (int i = 0; i < 20; i++)
			check_step($sformatf("random_b0 step %0d", i), 1'b0,
				rand_elem(), rand_elem(), rand_elem(), rand_elem(), rand_elem());
		finish_test("random_b0");

		start_test();
		for (int i = 0; i < 20; i++)
			check_step($sformatf("random_b1 step %0d", i), 1'b1,
				rand_elem(), rand_elem(), rand_elem(), rand_elem(), rand_elem());
		finish_test("random_b1");

		// every mix of 0, 1, P-1 over five operands
		start_test();
		for (int idx = 0; idx < 243; idx++)
			check_step($sformatf("edge_operands case %0d", idx), idx[0],
				edge_value(idx % 3), edge_value((idx / 3) % 3),
				edge_value((idx / 9) % 3), edge_value((idx / 27) % 3),
				edge_value((idx / 81) % 3));
		finish_test("edge_operands");

		// ladder from (1,0),(w,1), dut fed its own results
		start_test();
		k = 16'($urandom);
		w = rand_elem();
		mx = W'(1);
		mz = '0;
		mx1 = w;
		mz1 = W'(1);
		dx = mx;
		dz = mz;
		dx1 = mx1;
		dz1 = mz1;
		for (int i = 15; i >= 0; i--) begin
			model_step(k[i], mx, mz, mx1, mz1, w, mx, mz, mx1, mz1);
			pulse_en(k[i], dx, dz, dx1, dz1, w);
			wait_valid($sformatf("scalar_ladder bit %0d", i));
			compare_outputs($sformatf("scalar_ladder bit %0d", i), mx, mz, mx1, mz1);
			dx = x_n;
			dz = z_n;
			dx1 = x_n1;
			dz1 = z_n1;
		end
		finish_test("scalar_ladder");

		// stray en while busy, b and work held
		start_test();
		kb = 1'($urandom & 1);
		w = rand_elem();
		dx = rand_elem();
		dz = rand_elem();
		dx1 = rand_elem();
		dz1 = rand_elem();
		model_step(kb, dx, dz, dx1, dz1, w, mx, mz, mx1, mz1);
		pulse_en(kb, dx, dz, dx1, dz1, w);
		repeat (40) @(posedge clk);
		pulse_en(kb, rand_elem(), rand_elem(), rand_elem(), rand_elem(), w);
		wait_valid("second_en");
		compare_outputs("second_en", mx, mz, mx1, mz1);
		repeat (300) begin
			@(negedge clk);
			check_bit("second_en extra out_valid", 1'b0, out_valid);
		end
		finish_test("second_en");

		$display("checks passed %0d, failed %0d", check_pass, check_fail);
		if (check_fail == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
hdl/ladder_pkg.sv
hdl/field_addsub.sv
hdl/field_mult.sv
hdl/point_swap.sv
hdl/ladder_sequencer.sv
hdl/ladder_step.sv
bench/ladder_step_checker.sv
bench/ladder_step_tb.sv

/* hdl/field_addsub.sv */
`timescale 1ns/10ps

module field_addsub #(
	parameter int W = ladder_pkg::field_w_default,
	parameter int P = ladder_pkg::field_p_default
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  logic [W-1:0] a,
	input  logic [W-1:0] b,
	output logic         done,
	output logic [W-1:0] sum,
	output logic [W-1:0] diff
);

	// one spare bit for carry and borrow
	localparam logic [W:0] p_ext = (W+1)'(P);

	logic [W:0]   raw_sum;
	logic [W:0]   raw_diff;
	logic [W-1:0] sum_mod;
	logic [W-1:0] diff_mod;

	always_comb begin
		raw_sum  = {1'b0, a} + {1'b0, b};
		// a+b < 2P, so one subtraction is enough
		sum_mod  = (raw_sum >= p_ext) ? W'(raw_sum - p_ext) : raw_sum[W-1:0];
		raw_diff = {1'b0, a} - {1'b0, b};
		// borrow out means a < b, fold P back in
		diff_mod = raw_diff[W] ? W'(raw_diff + p_ext) : raw_diff[W-1:0];
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= start;
	end

	// results hold until the next start
	always_ff @(posedge clk) begin
		if (start) begin
			sum  <= sum_mod;
			diff <= diff_mod;
		end
	end

endmodule

/* hdl/field_mult.sv */
`timescale 1ns/10ps

module field_mult #(
	parameter int W = ladder_pkg::field_w_default,
	parameter int P = ladder_pkg::field_p_default
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  logic [W-1:0] a,
	input  logic [W-1:0] b,
	output logic         done,
	output logic [W-1:0] prod
);

	localparam int cnt_w = $clog2(W + 1);
	// two spare bits, doubling then adding stays below 4P
	localparam logic [W+1:0] p_ext = (W+2)'(P);

	logic [W-1:0]     a_r;
	logic [W-1:0]     b_r;
	logic [W-1:0]     acc;
	logic [cnt_w-1:0] cnt;
	logic             busy;
	logic [W+1:0]     dbl;
	logic [W+1:0]     dbl_red;
	logic [W+1:0]     add;
	logic [W+1:0]     add_red;

	// one horner step, msb of b first
	always_comb begin
		dbl     = {1'b0, acc, 1'b0};
		dbl_red = (dbl >= p_ext) ? dbl - p_ext : dbl;
		add     = dbl_red + (b_r[W-1] ? {2'b00, a_r} : '0);
		add_red = (add >= p_ext) ? add - p_ext : add;
	end

	////////////////////////////////////////////////////////////////////////////
	// bit counter, W steps after the start cycle

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= cnt_w'(W);
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				// last bit goes in this cycle
				if (cnt == cnt_w'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// operands and accumulator
	always_ff @(posedge clk) begin
		if (start) begin
			a_r <= a;
			b_r <= b;
			acc <= '0;
		end else if (busy) begin
			acc <= add_red[W-1:0];
			b_r <= b_r << 1;
		end
	end

	// accumulator holds the product after done
	assign prod = acc;

endmodule

/* hdl/ladder_pkg.sv */
package ladder_pkg;

	// default field, small enough for a cheap reference model
	localparam int field_w_default = 16;
	localparam int field_p_default = 65521;

	// curve constant, the sequencer reduces it mod P
	localparam int a24_value = 121665;

	////////////////////////////////////////////////////////////////////////////
	// one state per microcode line

	typedef enum logic [3:0] {
		st_idle        = 4'h0,
		st_select_done = 4'h1,
		st_a0          = 4'h2,
		st_b0_low      = 4'h3,
		st_b0_high     = 4'h4,
		st_b1_low      = 4'h5,
		st_b1_high     = 4'h6,
		st_c1          = 4'h7,
		st_r           = 4'h8,
		st_t           = 4'h9,
		st_xb_low      = 4'ha,
		st_xb_high     = 4'hb,
		st_xn_low      = 4'hc,
		st_xn_high     = 4'hd
	} step_state_t;

	////////////////////////////////////////////////////////////////////////////
	// temporary registers, lo is x and hi is z of a pair

	typedef enum logic [4:0] {
		reg_xzmb_lo  = 5'h00,
		reg_xzmb_hi  = 5'h01,
		reg_xzm1b_lo = 5'h02,
		reg_xzm1b_hi = 5'h03,
		reg_a0_lo    = 5'h04,
		reg_a0_hi    = 5'h05,
		reg_a1_lo    = 5'h06,
		reg_a1_hi    = 5'h07,
		reg_b0_lo    = 5'h08,
		reg_b0_hi    = 5'h09,
		reg_b1_lo    = 5'h0a,
		reg_b1_hi    = 5'h0b,
		reg_c1_lo    = 5'h0c,
		reg_c1_hi    = 5'h0d,
		reg_r        = 5'h0e,
		reg_s        = 5'h0f,
		reg_t        = 5'h10,
		reg_u        = 5'h11,
		reg_xznb_lo  = 5'h12,
		reg_xznb_hi  = 5'h13,
		reg_xzn1b_lo = 5'h14,
		reg_xzn1b_hi = 5'h15,
		// read only from here on
		reg_a24      = 5'h16,
		reg_zero     = 5'h17,
		reg_work     = 5'h18
	} reg_id_t;

	// one microcode line
	typedef struct packed {
		logic        swap_en;
		logic        as_en;
		logic        mul_en;
		reg_id_t     as_a;
		reg_id_t     as_b;
		reg_id_t     mul_a;
		reg_id_t     mul_b;
		reg_id_t     sum_dst;
		reg_id_t     diff_dst;
		reg_id_t     prod_dst;
		logic        next_on_as;
		logic        next_on_mul;
		logic        next_on_swap;
		step_state_t next;
	} ucode_t;

endpackage

/* hdl/ladder_sequencer.sv */
`timescale 1ns/10ps

module ladder_sequencer #(
	parameter int W = ladder_pkg::field_w_default,
	parameter int P = ladder_pkg::field_p_default
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         en,
	input  logic [W-1:0] x_m,
	input  logic [W-1:0] z_m,
	input  logic [W-1:0] x_m1,
	input  logic [W-1:0] z_m1,
	input  logic [W-1:0] work,
	output logic         swap_start,
	output logic [W-1:0] swap_r_x,
	output logic [W-1:0] swap_r_z,
	output logic [W-1:0] swap_s_x,
	output logic [W-1:0] swap_s_z,
	output logic         as_start,
	output logic [W-1:0] as_a,
	output logic [W-1:0] as_b,
	output logic         mul_start,
	output logic [W-1:0] mul_a,
	output logic [W-1:0] mul_b,
	input  logic         as_done,
	input  logic [W-1:0] sum,
	input  logic [W-1:0] diff,
	input  logic         mul_done,
	input  logic [W-1:0] prod,
	input  logic         swap_done,
	input  logic [W-1:0] p_x,
	input  logic [W-1:0] p_z,
	input  logic [W-1:0] q_x,
	input  logic [W-1:0] q_z,
	output logic         out_valid,
	output logic [W-1:0] x_n,
	output logic [W-1:0] z_n,
	output logic [W-1:0] x_n1,
	output logic [W-1:0] z_n1
);

	localparam int n_wr = int'(ladder_pkg::reg_xzn1b_hi) + 1;
	localparam logic [W-1:0] a24_mod = W'(ladder_pkg::a24_value % P);

	ladder_pkg::step_state_t state;
	ladder_pkg::ucode_t      line;
	logic [W-1:0]            regs [n_wr];
	logic                    advancing;
	logic                    advancing_ff;
	logic                    load_pend;
	logic                    accept;

	// register file read, constants decoded here
	function automatic logic [W-1:0] rd(input ladder_pkg::reg_id_t id);
		case (id)
			ladder_pkg::reg_a24:  return a24_mod;
			ladder_pkg::reg_zero: return '0;
			ladder_pkg::reg_work: return work;
			default:              return regs[id];
		endcase
	endfunction

	function automatic logic writable(input ladder_pkg::reg_id_t id);
		return id <= ladder_pkg::reg_xzn1b_hi;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// microcode rom, nacl mainloop order

	always_comb begin
		// idle, wait for the input swap
		line = {3'b000, ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
			ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
			ladder_pkg::reg_zero, 3'b001, ladder_pkg::st_select_done};
		case (state)
			// a0 = xzmb_lo +/- xzmb_hi
			ladder_pkg::st_select_done: line = {3'b010,
				ladder_pkg::reg_xzmb_lo, ladder_pkg::reg_xzmb_hi, ladder_pkg::reg_zero,
				ladder_pkg::reg_zero, ladder_pkg::reg_a0_lo, ladder_pkg::reg_a0_hi,
				ladder_pkg::reg_zero, 3'b100, ladder_pkg::st_a0};
			// a1 in parallel with a0_lo squared
			ladder_pkg::st_a0: line = {3'b011,
				ladder_pkg::reg_xzm1b_lo, ladder_pkg::reg_xzm1b_hi, ladder_pkg::reg_a0_lo,
				ladder_pkg::reg_a0_lo, ladder_pkg::reg_a1_lo, ladder_pkg::reg_a1_hi,
				ladder_pkg::reg_b0_lo, 3'b010, ladder_pkg::st_b0_low};
			ladder_pkg::st_b0_low: line = {3'b001,
				ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_a0_hi,
				ladder_pkg::reg_a0_hi, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
				ladder_pkg::reg_b0_hi, 3'b010, ladder_pkg::st_b0_high};
			// cross products into b1
			ladder_pkg::st_b0_high: line = {3'b001,
				ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_a1_lo,
				ladder_pkg::reg_a0_hi, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
				ladder_pkg::reg_b1_lo, 3'b010, ladder_pkg::st_b1_low};
			ladder_pkg::st_b1_low: line = {3'b001,
				ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_a1_hi,
				ladder_pkg::reg_a0_lo, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
				ladder_pkg::reg_b1_hi, 3'b010, ladder_pkg::st_b1_high};
			ladder_pkg::st_b1_high: line = {3'b010,
				ladder_pkg::reg_b1_lo, ladder_pkg::reg_b1_hi, ladder_pkg::reg_zero,
				ladder_pkg::reg_zero, ladder_pkg::reg_c1_lo, ladder_pkg::reg_c1_hi,
				ladder_pkg::reg_zero, 3'b100, ladder_pkg::st_c1};
			// s = b0_lo - b0_hi, sum thrown away; r = c1_hi squared
			ladder_pkg::st_c1: line = {3'b011,
				ladder_pkg::reg_b0_lo, ladder_pkg::reg_b0_hi, ladder_pkg::reg_c1_hi,
				ladder_pkg::reg_c1_hi, ladder_pkg::reg_zero, ladder_pkg::reg_s,
				ladder_pkg::reg_r, 3'b010, ladder_pkg::st_r};
			ladder_pkg::st_r: line = {3'b001,
				ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_s,
				ladder_pkg::reg_a24, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
				ladder_pkg::reg_t, 3'b010, ladder_pkg::st_t};
			// u = t + b0_lo alongside b0_lo * b0_hi
			ladder_pkg::st_t: line = {3'b011,
				ladder_pkg::reg_t, ladder_pkg::reg_b0_lo, ladder_pkg::reg_b0_lo,
				ladder_pkg::reg_b0_hi, ladder_pkg::reg_u, ladder_pkg::reg_zero,
				ladder_pkg::reg_xznb_lo, 3'b010, ladder_pkg::st_xb_low};
			ladder_pkg::st_xb_low: line = {3'b001,
				ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_s,
				ladder_pkg::reg_u, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
				ladder_pkg::reg_xznb_hi, 3'b010, ladder_pkg::st_xb_high};
			ladder_pkg::st_xb_high: line = {3'b001,
				ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_c1_lo,
				ladder_pkg::reg_c1_lo, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
				ladder_pkg::reg_xzn1b_lo, 3'b010, ladder_pkg::st_xn_low};
			ladder_pkg::st_xn_low: line = {3'b001,
				ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_r,
				ladder_pkg::reg_work, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
				ladder_pkg::reg_xzn1b_hi, 3'b010, ladder_pkg::st_xn_high};
			// swap back, results go out
			ladder_pkg::st_xn_high: line = {3'b100,
				ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
				ladder_pkg::reg_zero, ladder_pkg::reg_zero, ladder_pkg::reg_zero,
				ladder_pkg::reg_zero, 3'b001, ladder_pkg::st_idle};
			default: ;
		endcase

		advancing = (as_done && line.next_on_as) || (mul_done && line.next_on_mul) ||
			(swap_done && line.next_on_swap);
		// one load at a time, en elsewhere is dropped
		accept = en && (state == ladder_pkg::st_idle) && !load_pend;
	end

	////////////////////////////////////////////////////////////////////////////
	// state, write back, start strobes

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= ladder_pkg::st_idle;
			advancing_ff <= 1'b0;
			load_pend    <= 1'b0;
			swap_start   <= 1'b0;
			as_start     <= 1'b0;
			mul_start    <= 1'b0;
			out_valid    <= 1'b0;
			x_n          <= '0;
			z_n          <= '0;
			x_n1         <= '0;
			z_n1         <= '0;
			for (int i = 0; i < n_wr; i++)
				regs[i] <= '0;
		end else begin
			swap_start   <= 1'b0;
			as_start     <= 1'b0;
			mul_start    <= 1'b0;
			out_valid    <= 1'b0;
			advancing_ff <= advancing;

			// results land where the current line says
			if (as_done && writable(line.sum_dst))
				regs[line.sum_dst] <= sum;
			if (as_done && writable(line.diff_dst))
				regs[line.diff_dst] <= diff;
			if (mul_done && writable(line.prod_dst))
				regs[line.prod_dst] <= prod;

			if (swap_done) begin
				if (state == ladder_pkg::st_idle) begin
					regs[ladder_pkg::reg_xzmb_lo]  <= p_x;
					regs[ladder_pkg::reg_xzmb_hi]  <= p_z;
					regs[ladder_pkg::reg_xzm1b_lo] <= q_x;
					regs[ladder_pkg::reg_xzm1b_hi] <= q_z;
					load_pend                      <= 1'b0;
				end else if (state == ladder_pkg::st_xn_high) begin
					x_n       <= p_x;
					z_n       <= p_z;
					x_n1      <= q_x;
					z_n1      <= q_z;
					out_valid <= 1'b1;
				end
			end

			if (advancing)
				state <= line.next;
			// new line is live, kick its units
			if (advancing_ff) begin
				swap_start <= line.swap_en;
				as_start   <= line.as_en;
				mul_start  <= line.mul_en;
			end
			if (accept) begin
				swap_start <= 1'b1;
				load_pend  <= 1'b1;
			end
		end
	end

	// operand latch, one cycle after the advance
	always_ff @(posedge clk) begin
		if (advancing_ff) begin
			as_a  <= rd(line.as_a);
			as_b  <= rd(line.as_b);
			mul_a <= rd(line.mul_a);
			mul_b <= rd(line.mul_b);
		end
		if (advancing_ff && line.swap_en) begin
			swap_r_x <= rd(ladder_pkg::reg_xznb_lo);
			swap_r_z <= rd(ladder_pkg::reg_xznb_hi);
			swap_s_x <= rd(ladder_pkg::reg_xzn1b_lo);
			swap_s_z <= rd(ladder_pkg::reg_xzn1b_hi);
		end
		// input pairs go through the swap first
		if (accept) begin
			swap_r_x <= x_m;
			swap_r_z <= z_m;
			swap_s_x <= x_m1;
			swap_s_z <= z_m1;
		end
	end

endmodule

/* hdl/ladder_step.sv */
`timescale 1ns/10ps

module ladder_step #(
	parameter int W = ladder_pkg::field_w_default,
	parameter int P = ladder_pkg::field_p_default
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         en,
	input  logic         b,
	input  logic [W-1:0] x_m,
	input  logic [W-1:0] z_m,
	input  logic [W-1:0] x_m1,
	input  logic [W-1:0] z_m1,
	input  logic [W-1:0] work,
	output logic         out_valid,
	output logic [W-1:0] x_n,
	output logic [W-1:0] z_n,
	output logic [W-1:0] x_n1,
	output logic [W-1:0] z_n1
);

	////////////////////////////////////////////////////////////////////////////
	// shared unit strobes and operands

	logic         swap_start;
	logic [W-1:0] swap_r_x;
	logic [W-1:0] swap_r_z;
	logic [W-1:0] swap_s_x;
	logic [W-1:0] swap_s_z;
	logic         as_start;
	logic [W-1:0] as_a;
	logic [W-1:0] as_b;
	logic         mul_start;
	logic [W-1:0] mul_a;
	logic [W-1:0] mul_b;

	// unit results back to the sequencer
	logic         as_done;
	logic [W-1:0] sum;
	logic [W-1:0] diff;
	logic         mul_done;
	logic [W-1:0] prod;
	logic         swap_done;
	logic [W-1:0] p_x;
	logic [W-1:0] p_z;
	logic [W-1:0] q_x;
	logic [W-1:0] q_z;

	ladder_sequencer #(.W(W), .P(P)) u_seq (
		.clk(clk), .rst_n(rst_n), .en(en),
		.x_m(x_m), .z_m(z_m), .x_m1(x_m1), .z_m1(z_m1), .work(work),
		.swap_start(swap_start), .swap_r_x(swap_r_x), .swap_r_z(swap_r_z),
		.swap_s_x(swap_s_x), .swap_s_z(swap_s_z),
		.as_start(as_start), .as_a(as_a), .as_b(as_b),
		.mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b),
		.as_done(as_done), .sum(sum), .diff(diff),
		.mul_done(mul_done), .prod(prod),
		.swap_done(swap_done), .p_x(p_x), .p_z(p_z), .q_x(q_x), .q_z(q_z),
		.out_valid(out_valid), .x_n(x_n), .z_n(z_n), .x_n1(x_n1), .z_n1(z_n1)
	);

	field_addsub #(.W(W), .P(P)) u_addsub (
		.clk(clk), .rst_n(rst_n), .start(as_start), .a(as_a), .b(as_b),
		.done(as_done), .sum(sum), .diff(diff)
	);

	field_mult #(.W(W), .P(P)) u_mult (
		.clk(clk), .rst_n(rst_n), .start(mul_start), .a(mul_a), .b(mul_b),
		.done(mul_done), .prod(prod)
	);

	// key bit straight to the swap, both swaps of a step use it
	point_swap #(.W(W)) u_swap (
		.clk(clk), .rst_n(rst_n), .start(swap_start), .b(b),
		.r_x(swap_r_x), .r_z(swap_r_z), .s_x(swap_s_x), .s_z(swap_s_z),
		.done(swap_done), .p_x(p_x), .p_z(p_z), .q_x(q_x), .q_z(q_z)
	);

endmodule

/* hdl/point_swap.sv */
`timescale 1ns/10ps

module point_swap #(
	parameter int W = ladder_pkg::field_w_default
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  logic         b,
	input  logic [W-1:0] r_x,
	input  logic [W-1:0] r_z,
	input  logic [W-1:0] s_x,
	input  logic [W-1:0] s_z,
	output logic         done,
	output logic [W-1:0] p_x,
	output logic [W-1:0] p_z,
	output logic [W-1:0] q_x,
	output logic [W-1:0] q_z
);

	// key bit spread over a word, no branch on b
	logic [W-1:0] mask;

	assign mask = {W{b}};

	always_ff @(posedge clk) begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= start;
	end

	// p gets s when b is set, q gets the other one
	always_ff @(posedge clk) begin
		if (start) begin
			p_x <= (r_x & ~mask) | (s_x & mask);
			p_z <= (r_z & ~mask) | (s_z & mask);
			q_x <= (s_x & ~mask) | (r_x & mask);
			q_z <= (s_z & ~mask) | (r_z & mask);
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ladder step testbench with verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
	--top-module ladder_step_tb -o ladder_step_sim

# output goes to the terminal, the pass line decides the status
./obj_dir/ladder_step_sim | tee /dev/stderr | grep -x "TB PASSED" > /dev/null

echo "simulation run complete"
